/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_cpu
FILELIST ?= cpu.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(BUILD_DIR)

/* cpu.f */
hdl/wires.sv
hdl/alu.sv
hdl/register.sv
hdl/decoder.sv
hdl/fetch_stage.sv
hdl/execute_stage.sv
hdl/cpu.sv
verif/cpu_checker.sv
verif/tb_cpu.sv

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu
(
  input  wires::alu_op_t        op,
  input  logic [wires::xlen-1:0] a,
  input  logic [wires::xlen-1:0] b,
  output logic [wires::xlen-1:0] y,
  output logic                   zero
);

  always_comb begin
    case (op)
      wires::alu_add:    y = a + b;
      wires::alu_sub:    y = a - b;
      wires::alu_and:    y = a & b;
      wires::alu_or:     y = a | b;
      wires::alu_xor:    y = a ^ b;
      wires::alu_slt:    y = {{(wires::xlen-1){1'b0}}, $signed(a) < $signed(b)};
      wires::alu_pass_b: y = b;
      default:           y = '0;
    endcase
  end

  // equality for beq and bne.
  assign zero = (a == b);

endmodule

/* hdl/cpu.sv */
`timescale 1ns/1ps

module cpu
(
  input  logic                     clock,
  input  logic                     rst,
  output logic                     imemory_valid,
  output logic [wires::xlen-1:0]   imemory_addr,
  input  logic [wires::xlen-1:0]   imemory_rdata,
  input  logic                     imemory_ready,
  output logic                     dmemory_valid,
  output logic [wires::xlen-1:0]   dmemory_addr,
  output logic [wires::xlen-1:0]   dmemory_wdata,
  output logic [wires::xlen/8-1:0] dmemory_wstrb,
  input  logic [wires::xlen-1:0]   dmemory_rdata,
  input  logic                     dmemory_ready
);

  logic fetch_req;
  logic fetch_done;
  logic pc_load;
  logic [wires::xlen-1:0] pc_next;
  logic [wires::xlen-1:0] pc;
  logic [wires::xlen-1:0] instr;
  logic [wires::reg_addr_bits-1:0] rs1;
  logic [wires::reg_addr_bits-1:0] rs2;
  logic [wires::reg_addr_bits-1:0] rd;
  logic [wires::xlen-1:0] imm;
  wires::alu_op_t alu_op;
  wires::alu_op_t alu_op_sel;
  logic use_imm;
  logic is_load;
  logic is_store;
  logic is_branch;
  logic branch_ne;
  logic is_jal;
  logic writes_rd;
  logic illegal;
  logic [wires::xlen-1:0] rs1_data;
  logic [wires::xlen-1:0] rs2_data;
  logic rd_we;
  logic [wires::xlen-1:0] rd_data;
  logic [wires::xlen-1:0] alu_a;
  logic [wires::xlen-1:0] alu_b;
  logic [wires::xlen-1:0] alu_y;
  logic alu_zero;

  fetch_stage fetch_stage_comp
  (
    .clock         (clock),
    .rst           (rst),
    .fetch_req     (fetch_req),
    .pc_load       (pc_load),
    .pc_next       (pc_next),
    .imemory_rdata (imemory_rdata),
    .imemory_ready (imemory_ready),
    .imemory_valid (imemory_valid),
    .imemory_addr  (imemory_addr),
    .pc            (pc),
    .instr         (instr),
    .fetch_done    (fetch_done)
  );

  decoder decoder_comp
  (
    .instr     (instr),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm       (imm),
    .alu_op    (alu_op),
    .use_imm   (use_imm),
    .is_load   (is_load),
    .is_store  (is_store),
    .is_branch (is_branch),
    .branch_ne (branch_ne),
    .is_jal    (is_jal),
    .writes_rd (writes_rd),
    .illegal   (illegal)
  );

  register register_comp
  (
    .clock    (clock),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .rd_we    (rd_we),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu alu_comp
  (
    .op   (alu_op_sel),
    .a    (alu_a),
    .b    (alu_b),
    .y    (alu_y),
    .zero (alu_zero)
  );

  execute_stage execute_stage_comp
  (
    .clock         (clock),
    .rst           (rst),
    .fetch_done    (fetch_done),
    .pc            (pc),
    .imm           (imm),
    .alu_op        (alu_op),
    .use_imm       (use_imm),
    .is_load       (is_load),
    .is_store      (is_store),
    .is_branch     (is_branch),
    .branch_ne     (branch_ne),
    .is_jal        (is_jal),
    .writes_rd     (writes_rd),
    .illegal       (illegal),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .alu_y         (alu_y),
    .alu_zero      (alu_zero),
    .dmemory_rdata (dmemory_rdata),
    .dmemory_ready (dmemory_ready),
    .fetch_req     (fetch_req),
    .pc_load       (pc_load),
    .pc_next       (pc_next),
    .alu_a         (alu_a),
    .alu_b         (alu_b),
    .alu_op_sel    (alu_op_sel),
    .rd_we         (rd_we),
    .rd_data       (rd_data),
    .dmemory_valid (dmemory_valid),
    .dmemory_addr  (dmemory_addr),
    .dmemory_wdata (dmemory_wdata),
    .dmemory_wstrb (dmemory_wstrb)
  );

endmodule

/* hdl/decoder.sv */
`timescale 1ns/1ps

module decoder
(
  input  logic [wires::xlen-1:0]          instr,
  output logic [wires::reg_addr_bits-1:0] rs1,
  output logic [wires::reg_addr_bits-1:0] rs2,
  output logic [wires::reg_addr_bits-1:0] rd,
  output logic [wires::xlen-1:0]          imm,
  output wires::alu_op_t                  alu_op,
  output logic                            use_imm,
  output logic                            is_load,
  output logic                            is_store,
  output logic                            is_branch,
  output logic                            branch_ne,
  output logic                            is_jal,
  output logic                            writes_rd,
  output logic                            illegal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [wires::xlen-1:0] imm_i;
  logic [wires::xlen-1:0] imm_s;
  logic [wires::xlen-1:0] imm_b;
  logic [wires::xlen-1:0] imm_u;
  logic [wires::xlen-1:0] imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  assign is_load   = (opcode == wires::opcode_load);
  assign is_store  = (opcode == wires::opcode_store);
  assign is_branch = (opcode == wires::opcode_branch);
  assign is_jal    = (opcode == wires::opcode_jal);
  assign branch_ne = funct3[0];
  assign use_imm   = opcode inside {wires::opcode_lui, wires::opcode_op_imm,
                                    wires::opcode_load, wires::opcode_store};
  assign writes_rd = opcode inside {wires::opcode_lui, wires::opcode_op_imm,
                                    wires::opcode_op, wires::opcode_load, wires::opcode_jal};

  always_comb begin
    imm     = imm_i;
    alu_op  = wires::alu_add; // address sum for loads and stores.
    illegal = 1'b0;
    case (opcode)
      wires::opcode_lui: begin
        imm    = imm_u;
        alu_op = wires::alu_pass_b;
      end
      wires::opcode_op_imm: illegal = (funct3 != 3'b000); // addi only.
      wires::opcode_op: begin
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_op = wires::alu_add;
          {7'b0100000, 3'b000}: alu_op = wires::alu_sub;
          {7'b0000000, 3'b111}: alu_op = wires::alu_and;
          {7'b0000000, 3'b110}: alu_op = wires::alu_or;
          {7'b0000000, 3'b100}: alu_op = wires::alu_xor;
          {7'b0000000, 3'b010}: alu_op = wires::alu_slt;
          default:              illegal = 1'b1;
        endcase
      end
      wires::opcode_load:   illegal = (funct3 != 3'b010);
      wires::opcode_store: begin
        imm     = imm_s;
        illegal = (funct3 != 3'b010);
      end
      wires::opcode_branch: begin
        imm     = imm_b;
        illegal = (funct3[2:1] != 2'b00);
      end
      wires::opcode_jal:    imm = imm_j;
      default:              illegal = 1'b1;
    endcase
  end

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage
(
  input  logic                     clock,
  input  logic                     rst,
  input  logic                     fetch_done,
  input  logic [wires::xlen-1:0]   pc,
  input  logic [wires::xlen-1:0]   imm,
  input  wires::alu_op_t           alu_op,
  input  logic                     use_imm,
  input  logic                     is_load,
  input  logic                     is_store,
  input  logic                     is_branch,
  input  logic                     branch_ne,
  input  logic                     is_jal,
  input  logic                     writes_rd,
  input  logic                     illegal,
  input  logic [wires::xlen-1:0]   rs1_data,
  input  logic [wires::xlen-1:0]   rs2_data,
  input  logic [wires::xlen-1:0]   alu_y,
  input  logic                     alu_zero,
  input  logic [wires::xlen-1:0]   dmemory_rdata,
  input  logic                     dmemory_ready,
  output logic                     fetch_req,
  output logic                     pc_load,
  output logic [wires::xlen-1:0]   pc_next,
  output logic [wires::xlen-1:0]   alu_a,
  output logic [wires::xlen-1:0]   alu_b,
  output wires::alu_op_t           alu_op_sel,
  output logic                     rd_we,
  output logic [wires::xlen-1:0]   rd_data,
  output logic                     dmemory_valid,
  output logic [wires::xlen-1:0]   dmemory_addr,
  output logic [wires::xlen-1:0]   dmemory_wdata,
  output logic [wires::xlen/8-1:0] dmemory_wstrb
);

  wires::core_state_t state;
  logic fetch_wait; // request issued but instruction not yet back.
  logic [wires::xlen-1:0] load_data;
  logic [wires::xlen-1:0] pc_plus4;
  logic taken;

  always_ff @(posedge clock) begin
    if (rst) begin
      state         <= wires::st_fetch;
      fetch_req     <= 1'b0;
      fetch_wait    <= 1'b0;
      dmemory_valid <= 1'b0;
    end else begin
      fetch_req <= 1'b0;
      case (state)
        wires::st_fetch: begin
          if (!fetch_wait) begin
            fetch_req  <= 1'b1;
            fetch_wait <= 1'b1;
          end else if (fetch_done) begin
            fetch_wait <= 1'b0;
            state      <= wires::st_exec;
          end
        end
        wires::st_exec: begin
          if (!illegal && (is_load || is_store)) begin
            dmemory_valid <= 1'b1;
            state         <= wires::st_mem;
          end else begin
            state <= wires::st_wb; // illegal words retire as a no-op.
          end
        end
        wires::st_mem: begin
          if (dmemory_ready) begin
            dmemory_valid <= 1'b0;
            state         <= wires::st_wb;
          end
        end
        default: state <= wires::st_fetch;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == wires::st_exec) begin
      dmemory_addr  <= alu_y;
      dmemory_wdata <= rs2_data;
      dmemory_wstrb <= {(wires::xlen/8){is_store}};
    end
    if (state == wires::st_mem && dmemory_ready) begin
      load_data <= dmemory_rdata;
    end
  end

  assign alu_a      = rs1_data;
  assign alu_b      = use_imm ? imm : rs2_data;
  assign alu_op_sel = alu_op;

  assign pc_plus4 = pc + 32'd4;
  assign taken    = !illegal && ((is_branch && (alu_zero ^ branch_ne)) || is_jal);
  assign pc_next  = taken ? pc + imm : pc_plus4;
  assign pc_load  = (state == wires::st_wb);

  assign rd_we   = (state == wires::st_wb) && writes_rd && !illegal;
  assign rd_data = is_load ? load_data : (is_jal ? pc_plus4 : alu_y);

endmodule

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage
(
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   fetch_req,
  input  logic                   pc_load,
  input  logic [wires::xlen-1:0] pc_next,
  input  logic [wires::xlen-1:0] imemory_rdata,
  input  logic                   imemory_ready,
  output logic                   imemory_valid,
  output logic [wires::xlen-1:0] imemory_addr,
  output logic [wires::xlen-1:0] pc,
  output logic [wires::xlen-1:0] instr,
  output logic                   fetch_done
);

  logic accept;

  assign accept = imemory_valid && imemory_ready;

  always_ff @(posedge clock) begin
    if (rst) begin
      pc            <= wires::reset_pc;
      imemory_valid <= 1'b0;
      fetch_done    <= 1'b0;
    end else begin
      fetch_done <= 1'b0;
      if (pc_load) begin
        pc <= pc_next;
      end
      if (fetch_req) begin
        imemory_valid <= 1'b1;
      end else if (accept) begin
        imemory_valid <= 1'b0;
        fetch_done    <= 1'b1; // instr is valid from here on.
      end
    end
  end

  // hold the word until the next fetch completes.
  always_ff @(posedge clock) begin
    if (accept) begin
      instr <= imemory_rdata;
    end
  end

  assign imemory_addr = pc;

endmodule

/* hdl/register.sv */
`timescale 1ns/1ps

module register
(
  input  logic                            clock,
  input  logic                            rst,
  input  logic [wires::reg_addr_bits-1:0] rs1,
  input  logic [wires::reg_addr_bits-1:0] rs2,
  input  logic [wires::reg_addr_bits-1:0] rd,
  input  logic                            rd_we,
  input  logic [wires::xlen-1:0]          rd_data,
  output logic [wires::xlen-1:0]          rs1_data,
  output logic [wires::xlen-1:0]          rs2_data
);

  logic [wires::xlen-1:0] regs [1:31]; // no storage for x0.

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hdl/wires.sv */
package wires;

  localparam int xlen = 32;
  localparam int reg_addr_bits = 5;

  localparam logic [xlen-1:0] reset_pc = '0;

  localparam logic [6:0] opcode_lui    = 7'b0110111;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_load   = 7'b0000011;
  localparam logic [6:0] opcode_store  = 7'b0100011;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_jal    = 7'b1101111;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b // lui result.
  } alu_op_t;

  typedef enum logic [1:0] {
    st_fetch,
    st_exec,
    st_mem,
    st_wb
  } core_state_t;

endpackage

/* verif/cpu_checker.sv */
`timescale 1ns/1ps

module cpu_checker
(
  input  logic        clock,
  input  logic        rst,
  input  logic        dmemory_valid,
  input  logic        dmemory_ready,
  input  logic [31:0] dmemory_addr,
  input  logic [31:0] dmemory_wdata,
  input  logic [3:0]  dmemory_wstrb,
  input  logic [31:0] store_count,
  input  logic [31:0] exp_addr [0:15],
  input  logic [31:0] exp_data [0:15],
  output logic [31:0] seen_count,
  output logic [31:0] error_count
);

  // a write is accepted on the edge where valid and ready are both high.
  always @(posedge clock) begin
    int errs;
    logic [3:0] slot;
    errs = 0;
    slot = seen_count[3:0];
    if (rst) begin
      seen_count  <= 32'h0;
      error_count <= 32'h0;
    end else if (dmemory_valid && dmemory_ready && dmemory_wstrb != 4'h0) begin
      if (seen_count >= store_count) begin
        $display("extra store of 0x%08h to address 0x%08h after the last expected one",
                 dmemory_wdata, dmemory_addr);
        errs = 1;
      end else begin
        if (dmemory_wstrb != 4'hf) begin
          $display("** Error dmemory_wstrb: got 0x%h, expected 0xf", dmemory_wstrb);
          errs = errs + 1;
        end
        if (dmemory_addr != exp_addr[slot]) begin
          $display("** Error dmemory_addr: got 0x%08h, expected 0x%08h (store %0d)",
                   dmemory_addr, exp_addr[slot], seen_count);
          errs = errs + 1;
        end
        if (dmemory_wdata != exp_data[slot]) begin
          $display("** Error dmemory_wdata: got 0x%08h, expected 0x%08h (store %0d)",
                   dmemory_wdata, exp_data[slot], seen_count);
          errs = errs + 1;
        end
      end
      seen_count  <= seen_count + 1;
      error_count <= error_count + errs;
    end
  end

endmodule

/* verif/cpu_testdata.hex */
// word 0 program length, word 1 store count, then the program words,
// then one line per expected store with address and data.
0000001e 0000000a
123450b7 // 00 lui  x1, 0x12345
10000113 // 04 addi x2, x0, 0x100
67808193 // 08 addi x3, x1, 0x678
ffb00213 // 0c addi x4, x0, -5
004182b3 // 10 add  x5, x3, x4
40320333 // 14 sub  x6, x4, x3
00512023 // 18 sw   x5, 0(x2)
00612223 // 1c sw   x6, 4(x2)
0051f3b3 // 20 and  x7, x3, x5
0020e433 // 24 or   x8, x1, x2
0051c4b3 // 28 xor  x9, x3, x5
00322533 // 2c slt  x10, x4, x3
00712423 // 30 sw   x7, 8(x2)
00812623 // 34 sw   x8, 12(x2)
00912823 // 38 sw   x9, 16(x2)
00a12a23 // 3c sw   x10, 20(x2)
00412603 // 40 lw   x12, 4(x2)
00700013 // 44 addi x0, x0, 7
00c12c23 // 48 sw   x12, 24(x2)
00012e23 // 4c sw   x0, 28(x2)
00528463 // 50 beq  x5, x5, +8
02112023 // 54 sw   x1, 32(x2) skipped
00629463 // 58 bne  x5, x6, +8
02112023 // 5c sw   x1, 32(x2) skipped
00628463 // 60 beq  x5, x6, +8 not taken
02312023 // 64 sw   x3, 32(x2)
0080076f // 68 jal  x14, +8
02112223 // 6c sw   x1, 36(x2) skipped
02e12223 // 70 sw   x14, 36(x2)
0000006f // 74 jal  x0, 0
00000100 12345673
00000104 edcba983
00000108 12345670
0000010c 12345100
00000110 0000000b
00000114 00000001
00000118 edcba983
0000011c 00000000
00000120 12345678
00000124 0000006c

/* verif/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;

  localparam int max_words = 64;
  localparam int max_stores = 16;
  localparam int timeout_cycles = 4000;

  logic        clock = 1'b0;
  logic        rst = 1'b1;
  logic        imemory_valid;
  logic [31:0] imemory_addr;
  logic [31:0] imemory_rdata = 32'h0;
  logic        imemory_ready = 1'b0;
  logic        dmemory_valid;
  logic [31:0] dmemory_addr;
  logic [31:0] dmemory_wdata;
  logic [3:0]  dmemory_wstrb;
  logic [31:0] dmemory_rdata = 32'h0;
  logic        dmemory_ready = 1'b0;

  logic [31:0] testdata [0:127];
  logic [31:0] rom [0:max_words-1];
  logic [31:0] ram [0:255];
  logic [31:0] exp_addr [0:max_stores-1];
  logic [31:0] exp_data [0:max_stores-1];
  logic [31:0] store_count = 32'h0;
  logic [31:0] seen_count;
  logic [31:0] error_count;
  integer seed = 29;
  integer iwait = -1; // cycles left before ready or -1 when idle.
  integer dwait = -1;

  always #4 clock = ~clock;

  cpu UUT (
    .clock         (clock),
    .rst           (rst),
    .imemory_valid (imemory_valid),
    .imemory_addr  (imemory_addr),
    .imemory_rdata (imemory_rdata),
    .imemory_ready (imemory_ready),
    .dmemory_valid (dmemory_valid),
    .dmemory_addr  (dmemory_addr),
    .dmemory_wdata (dmemory_wdata),
    .dmemory_wstrb (dmemory_wstrb),
    .dmemory_rdata (dmemory_rdata),
    .dmemory_ready (dmemory_ready)
  );

  cpu_checker store_check (
    .clock         (clock),
    .rst           (rst),
    .dmemory_valid (dmemory_valid),
    .dmemory_ready (dmemory_ready),
    .dmemory_addr  (dmemory_addr),
    .dmemory_wdata (dmemory_wdata),
    .dmemory_wstrb (dmemory_wstrb),
    .store_count   (store_count),
    .exp_addr      (exp_addr),
    .exp_data      (exp_data),
    .seen_count    (seen_count),
    .error_count   (error_count)
  );

  // words beyond the program read as zero, which the core retires as a no-op.
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if (addr[31:8] == 24'h0) begin
      return rom[addr[7:2]];
    end
    return 32'h0;
  endfunction

  // instruction and data memory models with one ready strobe per request.
  always @(negedge clock) begin
    if (rst) begin
      imemory_ready = 1'b0;
      dmemory_ready = 1'b0;
      iwait = -1;
      dwait = -1;
      for (int i = 0; i < 256; i++) begin
        ram[i[7:0]] = 32'hd00d0000 ^ (i << 2);
      end
    end else begin
      if (imemory_ready) begin
        imemory_ready = 1'b0;
      end else if (imemory_valid) begin
        if (iwait < 0) begin
          iwait = {$random(seed)} % 4;
        end
        if (iwait == 0) begin
          imemory_rdata = fetch_word(imemory_addr);
          imemory_ready = 1'b1;
        end
        iwait = iwait - 1;
      end
      if (dmemory_ready) begin
        dmemory_ready = 1'b0;
      end else if (dmemory_valid) begin
        if (dwait < 0) begin
          dwait = {$random(seed)} % 4;
        end
        if (dwait == 0) begin
          if (dmemory_wstrb != 4'h0) begin
            ram[dmemory_addr[9:2]] = dmemory_wdata;
          end
          dmemory_rdata = ram[dmemory_addr[9:2]];
          dmemory_ready = 1'b1;
        end
        dwait = dwait - 1;
      end
    end
  end

  initial begin
    int prog_len;
    int failures;
    int cycles;
    int k;
    failures = 0;
    for (int i = 0; i < max_words; i++) begin
      rom[i[5:0]] = 32'h0;
    end
    $readmemh("verif/cpu_testdata.hex", testdata);
    prog_len = testdata[0];
    if (prog_len > max_words || testdata[1] > max_stores) begin
      $display("test data does not fit the testbench memories");
      failures = failures + 1;
    end else begin
      store_count = testdata[1];
      for (int i = 0; i < prog_len; i++) begin
        k = 2 + i;
        rom[i[5:0]] = testdata[k[6:0]];
      end
      for (int j = 0; j < max_stores; j++) begin
        k = 2 + prog_len + 2 * j;
        exp_addr[j[3:0]] = testdata[k[6:0]];
        k = k + 1;
        exp_data[j[3:0]] = testdata[k[6:0]];
      end
      repeat (8) @(posedge clock);
      @(negedge clock);
      rst = 1'b0;
      cycles = 0;
      while (seen_count < store_count && cycles < timeout_cycles) begin
        @(negedge clock);
        cycles = cycles + 1;
      end
      if (seen_count < store_count) begin
        $display("timeout, only %0d of %0d expected stores arrived", seen_count, store_count);
        failures = failures + 1;
      end
      repeat (40) @(negedge clock); // the program parks in a jal loop that stores nothing.
    end
    $display("stores seen %0d of %0d, compare errors %0d, run failures %0d",
             seen_count, store_count, error_count, failures);
    if (failures == 0 && error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
